/* dv/dcache_patterns.txt */
// op (0 load, 1 store)  addr  size (0 byte, 1 half, 2 word, 3 double)  data  load value  hit
// An untouched memory byte at address a holds a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]
0 00000100 2 00000000 02030001 0
0 00000104 2 00000000 06070405 1
0 00000103 0 00000000 00000002 1
0 00000106 1 00000000 00000607 1
0 00000100 3 00000000 02030001 1
1 00000101 0 000000aa 00000000 1
1 00000102 1 0000bbcc 00000000 1
1 00000104 2 11223344 00000000 1
0 00000100 2 00000000 bbccaa01 1
0 00000106 1 00000000 00001122 1
0 00000105 0 00000000 00000033 1
1 00000100 3 deadbeef 00000000 1
0 00000100 2 00000000 deadbeef 1
0 00000107 0 00000000 00000000 1
1 00000208 1 00005566 00000000 0
0 00000208 2 00000000 09085566 1
0 0000020c 2 00000000 0d0c0f0e 1
0 00001100 2 00000000 12131011 0
0 00000100 2 00000000 deadbeef 0
0 00001104 2 00000000 16171415 0
0 00001107 0 00000000 00000016 1
1 00000100 2 0badf00d 00000000 0
0 00000100 2 00000000 0badf00d 1
0 00000104 0 00000000 00000000 1
0 00001104 1 00000000 00001415 0
0 12345678 2 00000000 0b0a0908 0
1 12345679 0 0000007f 00000000 1
0 12345678 2 00000000 0b0a7f08 1
0 1234567d 0 00000000 0000000d 1

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int MAX_LINES = 64;
    localparam int CYCLES_PER_LINE = 200;

    logic               clock;
    logic               reset;
    logic               req_valid;
    logic               req_is_store;
    logic [ADDR_W-1:0]  req_addr;
    mem_size_e          req_size;
    logic [DATA_W-1:0]  req_data;
    logic               stall;
    logic               load_valid;
    logic [DATA_W-1:0]  load_data;
    mem_command_e       proc2mem_command;
    logic [ADDR_W-1:0]  proc2mem_addr;
    logic [BLOCK_W-1:0] proc2mem_data;
    logic [TAG_W-1:0]   mem2proc_transaction_tag;
    logic [BLOCK_W-1:0] mem2proc_data;
    logic [TAG_W-1:0]   mem2proc_data_tag;

    logic [31:0]        patterns [6*MAX_LINES];     // Six columns per request
    int                 pattern_count;
    logic               loaded;
    logic               cur_is_store;
    logic [ADDR_W-1:0]  expect_addr;
    logic [BLOCK_W-1:0] expect_block;
    logic [TAG_W-1:0]   load_tag;
    logic               check_stall;
    logic               want_stall;

    dcache_top #(.NUM_LINES(32)) UUT (.*);

    mem_model memory (
        .clock(clock),
        .reset(reset),
        .command(proc2mem_command),
        .addr(proc2mem_addr),
        .store_data(proc2mem_data),
        .transaction_tag(mem2proc_transaction_tag),
        .data(mem2proc_data),
        .data_tag(mem2proc_data_tag)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Little-endian byte lanes, bytes past the block end are lost
    function automatic logic [BLOCK_W-1:0] apply_store(input logic [BLOCK_W-1:0] block,
            input logic [2:0] offset, input mem_size_e size, input logic [DATA_W-1:0] value);
        logic [BLOCK_W-1:0] wide;
        wide = BLOCK_W'(value);
        for (int i = 0; i < (1 << size); i++) begin
            if (int'(offset) + i < BLOCK_BYTES) begin
                block[8*(int'(offset)+i) +: 8] = wide[8*i +: 8];
            end
        end
        return block;
    endfunction

    task automatic run_request(input int n);
        logic              is_store;
        logic [ADDR_W-1:0] addr;
        mem_size_e         size;
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] expected;
        logic              exp_hit;
        mem_command_e      exp_cmd;
        is_store = patterns[6*n][0];
        addr     = patterns[6*n+1];
        size     = mem_size_e'(patterns[6*n+2][1:0]);
        value    = patterns[6*n+3];
        expected = patterns[6*n+4];
        exp_hit  = patterns[6*n+5][0];
        exp_cmd  = !exp_hit ? MEM_LOAD : (is_store ? MEM_STORE : MEM_NONE);
        @(negedge clock);
        while (stall) @(negedge clock);
        cur_is_store = is_store;
        if (is_store) begin
            expect_addr  = {addr[ADDR_W-1:OFFSET_W], 3'b000};
            expect_block = apply_store(memory.read_block(addr), addr[2:0], size, value);
        end
        @(posedge clock);
        req_valid    <= 1'b1;
        req_is_store <= is_store;
        req_addr     <= addr;
        req_size     <= size;
        req_data     <= value;
        @(negedge clock);
        assert (proc2mem_command == exp_cmd && load_valid == (exp_hit && !is_store) &&
                (exp_cmd == MEM_NONE || proc2mem_addr == {addr[ADDR_W-1:OFFSET_W], 3'b000}))
        else fail_run($sformatf("ERR %0t: line %0d command %0d load_valid %b, expected %0d",
                                $time, n, proc2mem_command, load_valid, exp_cmd));
        if (!is_store && !exp_hit) begin
            @(posedge clock);
            req_valid <= 1'b0;
            @(negedge clock);
            while (!load_valid) @(negedge clock);   // Miss latency depends on memory
        end
        if (!is_store) begin
            assert (load_data == expected)
            else fail_run($sformatf("ERR %0t: line %0d load data %h, expected %h",
                                    $time, n, load_data, expected));
        end
        @(posedge clock);
        req_valid <= 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (check_stall) begin
                assert (stall == want_stall)
                else fail_run($sformatf("ERR %0t: stall %b, expected %b",
                                        $time, stall, want_stall));
            end
            // A load or a refused command keeps the cache busy, an accepted store frees it
            check_stall = (proc2mem_command != MEM_NONE);
            want_stall  = (proc2mem_command == MEM_LOAD) || (mem2proc_transaction_tag == '0);
            if (proc2mem_command == MEM_LOAD && mem2proc_transaction_tag != '0) begin
                load_tag = mem2proc_transaction_tag;
            end
            if (proc2mem_command == MEM_STORE) begin
                assert (cur_is_store && proc2mem_addr == expect_addr &&
                        proc2mem_data == expect_block)
                else fail_run($sformatf("ERR %0t: store of %h to %h, expected %h to %h",
                        $time, proc2mem_data, proc2mem_addr, expect_block, expect_addr));
            end
            if (load_valid && stall) begin                  // Miss completing
                assert (load_tag != '0 && mem2proc_data_tag == load_tag)
                else fail_run($sformatf("ERR %0t: load completed with data tag %0d, wanted %0d",
                                        $time, mem2proc_data_tag, load_tag));
                load_tag = '0;
            end
            assert (!(load_valid && cur_is_store))
            else fail_run("The cache raised load_valid while a store was in progress");
        end
    end

    initial begin
        wait (loaded);
        repeat (CYCLES_PER_LINE * pattern_count + 20) @(posedge clock);
        fail_run("Timeout: the request stream did not finish within its cycle budget");
    end

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_is_store = 1'b0;
        req_addr     = '0;
        req_size     = SIZE_BYTE;
        req_data     = '0;
        cur_is_store = 1'b0;
        load_tag     = '0;
        check_stall  = 1'b0;
        want_stall   = 1'b0;
        loaded       = 1'b0;
        for (int i = 0; i < 6*MAX_LINES; i++) begin
            patterns[i] = '1;                       // All ones marks the end of the list
        end
        $readmemh("dv/dcache_patterns.txt", patterns);
        pattern_count = 0;
        while (pattern_count < MAX_LINES && patterns[6*pattern_count] != '1) begin
            pattern_count++;
        end
        loaded = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!stall && !load_valid && proc2mem_command == MEM_NONE)
        else fail_run("The cache was not idle after reset");
        for (int n = 0; n < pattern_count; n++) begin
            run_request(n);
        end
        if (pattern_count == 0) begin
            fail_run("No requests were read from the pattern file");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model import dcache_pkg::*; #(
    parameter int INDEX_W = 12
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire  mem_command_e  command,
    input  wire  [ADDR_W-1:0]   addr,
    input  wire  [BLOCK_W-1:0]  store_data,
    output logic [TAG_W-1:0]    transaction_tag,
    output logic [BLOCK_W-1:0]  data,
    output logic [TAG_W-1:0]    data_tag
);

    localparam int NUM_SLOTS = 1 << INDEX_W;

    logic [BLOCK_W-1:0]         blocks [NUM_SLOTS];
    logic [ADDR_W-OFFSET_W-1:0] owner  [NUM_SLOTS];    // Block address held in each slot
    logic [NUM_SLOTS-1:0]       written;

    logic [31:0]        rng;
    logic               accept;
    logic [TAG_W-1:0]   next_tag;
    logic               pending;
    logic [TAG_W-1:0]   pending_tag;
    logic [BLOCK_W-1:0] pending_block;
    logic [2:0]         countdown;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Untouched bytes hold the XOR of all four address bytes
    function automatic logic [BLOCK_W-1:0] fill_block(input logic [ADDR_W-1:0] a);
        logic [BLOCK_W-1:0] block;
        logic [ADDR_W-1:0]  byte_addr;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            byte_addr = {a[ADDR_W-1:OFFSET_W], 3'(i)};
            block[8*i +: 8] = byte_addr[7:0] ^ byte_addr[15:8] ^ byte_addr[23:16] ^
                              byte_addr[31:24];
        end
        return block;
    endfunction

    function automatic logic [BLOCK_W-1:0] read_block(input logic [ADDR_W-1:0] a);
        logic [INDEX_W-1:0] slot;
        slot = a[OFFSET_W +: INDEX_W];
        if (written[slot] && owner[slot] == a[ADDR_W-1:OFFSET_W]) begin
            return blocks[slot];
        end
        return fill_block(a);
    endfunction

    assign transaction_tag = (command != MEM_NONE && accept) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            rng      <= 32'ha75;
            accept   <= 1'b0;
            next_tag <= 1;
            pending  <= 1'b0;
            written  <= '0;
            data_tag <= '0;
            data     <= '0;
        end else begin
            rng      <= next_random(rng);
            accept   <= (rng[1:0] != 2'b00);       // Roughly one refusal in four
            data_tag <= '0;
            if (transaction_tag != '0) begin
                next_tag <= (next_tag == '1) ? TAG_W'(1) : next_tag + 1'b1;
                if (command == MEM_LOAD) begin
                    pending       <= 1'b1;
                    pending_tag   <= transaction_tag;
                    pending_block <= read_block(addr);
                    countdown     <= rng[4:2];     // Data comes 2 to 9 cycles later
                end else begin
                    blocks[addr[OFFSET_W +: INDEX_W]]  <= store_data;
                    owner[addr[OFFSET_W +: INDEX_W]]   <= addr[ADDR_W-1:OFFSET_W];
                    written[addr[OFFSET_W +: INDEX_W]] <= 1'b1;
                end
            end else if (pending) begin
                if (countdown == 0) begin
                    data_tag <= pending_tag;
                    data     <= pending_block;
                    pending  <= 1'b0;
                end else begin
                    countdown <= countdown - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cache_fill_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_fill_if import dcache_pkg::*; ();

    logic               fill_valid;
    logic [ADDR_W-1:0]  fill_addr;
    logic [BLOCK_W-1:0] fill_block;           // Block as returned by memory
    logic               store_valid;
    logic [ADDR_W-1:0]  store_addr;
    mem_size_e          store_size;
    logic [BLOCK_W-1:0] store_data;

    modport mshr_side (
        output fill_valid,
        output fill_addr,
        output fill_block,
        output store_valid,
        output store_addr,
        output store_size,
        output store_data
    );

    modport array_side (
        input fill_valid,
        input fill_addr,
        input fill_block,
        input store_valid,
        input store_addr,
        input store_size,
        input store_data
    );

endinterface

`default_nettype wire

/* logic/dcache_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_array import dcache_pkg::*; #(
    parameter int NUM_LINES = 32
) (
    input  wire                 clock,
    input  wire                 reset,

    input  wire  [ADDR_W-1:0]   lookup_addr,
    input  wire  mem_size_e     lookup_size,
    input  wire                 lookup_is_store,
    input  wire  [BLOCK_W-1:0]  lookup_data,

    output logic                hit,
    output logic [BLOCK_W-1:0]  line_block,
    output logic [DATA_W-1:0]   load_data,

    cache_fill_if.array_side    fill
);

    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int CTAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic [CTAG_W-1:0]   tags   [NUM_LINES];
    logic [BLOCK_W-1:0]  blocks [NUM_LINES];
    logic [NUM_LINES-1:0] valid;

    logic [OFFSET_W-1:0] lookup_offset;
    logic [INDEX_W-1:0]  lookup_index;
    logic [CTAG_W-1:0]   lookup_tag;

    logic [INDEX_W-1:0]  fill_index;
    logic [CTAG_W-1:0]   fill_tag;
    logic [INDEX_W-1:0]  store_index;
    logic [OFFSET_W-1:0] store_offset;

    logic [BLOCK_W-1:0]  stored_block;
    logic [BLOCK_W-1:0]  read_block;
    logic [BLOCK_W-1:0]  fill_merged;
    logic [BLOCK_W-1:0]  hit_merged;

    // Loads are zero extended, a double returns its low word
    function automatic logic [DATA_W-1:0] extract_load(
        input logic [BLOCK_W-1:0]  block,
        input logic [OFFSET_W-1:0] offset,
        input mem_size_e           size
    );
        logic [BLOCK_W-1:0] shifted;
        shifted = block >> (8 * offset);
        case (size)
            SIZE_BYTE: extract_load = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            SIZE_HALF: extract_load = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            default:   extract_load = shifted[DATA_W-1:0];
        endcase
    endfunction

    assign lookup_offset = lookup_addr[OFFSET_W-1:0];
    assign lookup_index  = lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag    = lookup_addr[ADDR_W-1 -: CTAG_W];

    assign fill_index   = fill.fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag     = fill.fill_addr[ADDR_W-1 -: CTAG_W];
    assign store_index  = fill.store_addr[OFFSET_W +: INDEX_W];
    assign store_offset = fill.store_addr[OFFSET_W-1:0];

    assign stored_block = blocks[lookup_index];
    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

    // A store sees the block as it will stand after the write
    assign line_block = lookup_is_store ?
        merge_store(stored_block, lookup_offset, lookup_size, lookup_data) : stored_block;

    // Fill data is not in the array yet when the load completes
    assign read_block = fill.fill_valid ? fill.fill_block : stored_block;
    assign load_data  = extract_load(read_block, lookup_offset, lookup_size);

    assign fill_merged = fill.store_valid ?
        merge_store(fill.fill_block, store_offset, fill.store_size, fill.store_data) :
        fill.fill_block;
    assign hit_merged = merge_store(blocks[store_index], store_offset, fill.store_size,
                                    fill.store_data);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (fill.fill_valid) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.fill_valid) begin
            tags[fill_index]   <= fill_tag;
            blocks[fill_index] <= fill_merged;
        end else if (fill.store_valid) begin
            blocks[store_index] <= hit_merged;  // Write-through store hit
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BLOCK_W = 64;
    localparam int TAG_W = 4;                 // Tag zero means no transaction
    localparam int OFFSET_W = 3;
    localparam int BLOCK_BYTES = BLOCK_W / 8;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_command_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD,
        SIZE_DOUBLE
    } mem_size_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACCEPT,
        WAIT_DATA,
        STORE_RETRY
    } mshr_state_e;

    typedef struct packed {
        mshr_state_e        state;
        logic [ADDR_W-1:0]  addr;
        logic [BLOCK_W-1:0] data;             // Request data, zero extended
        mem_size_e          size;
        logic               is_store;
        logic [TAG_W-1:0]   mem_tag;
    } mshr_entry_t;

    function automatic logic [BLOCK_BYTES-1:0] size_mask(input mem_size_e size);
        case (size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    endfunction

    // Bytes that would run past the end of the block are dropped
    function automatic logic [BLOCK_W-1:0] merge_store(
        input logic [BLOCK_W-1:0]  block,
        input logic [OFFSET_W-1:0] offset,
        input mem_size_e           size,
        input logic [BLOCK_W-1:0]  data
    );
        logic [BLOCK_BYTES-1:0] byte_en;
        logic [BLOCK_W-1:0]     lanes;
        logic [BLOCK_W-1:0]     merged;
        byte_en = size_mask(size) << offset;
        lanes = data << (8 * offset);
        merged = block;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            if (byte_en[i]) begin
                merged[8*i +: 8] = lanes[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int NUM_LINES = 32
) (
    input  wire                 clock,
    input  wire                 reset,

    input  wire                 req_valid,
    input  wire                 req_is_store,
    input  wire  [ADDR_W-1:0]   req_addr,
    input  wire  mem_size_e     req_size,
    input  wire  [DATA_W-1:0]   req_data,

    output logic                stall,
    output logic                load_valid,
    output logic [DATA_W-1:0]   load_data,

    output mem_command_e        proc2mem_command,
    output logic [ADDR_W-1:0]   proc2mem_addr,
    output logic [BLOCK_W-1:0]  proc2mem_data,

    input  wire  [TAG_W-1:0]    mem2proc_transaction_tag,
    input  wire  [BLOCK_W-1:0]  mem2proc_data,
    input  wire  [TAG_W-1:0]    mem2proc_data_tag
);

    cache_fill_if fill_bus ();

    logic               hit;
    logic [BLOCK_W-1:0] line_block;
    logic [ADDR_W-1:0]  lookup_addr;
    mem_size_e          lookup_size;
    logic               lookup_is_store;
    logic [BLOCK_W-1:0] lookup_data;

    // While busy only a pending store still reads the line
    assign lookup_addr     = stall ? fill_bus.fill_addr : req_addr;
    assign lookup_size     = stall ? fill_bus.store_size : req_size;
    assign lookup_is_store = stall ? 1'b1 : req_is_store;
    assign lookup_data     = stall ? fill_bus.store_data : BLOCK_W'(req_data);

    dcache_array #(
        .NUM_LINES(NUM_LINES)
    ) u_array (
        .clock(clock),
        .reset(reset),
        .lookup_addr(lookup_addr),
        .lookup_size(lookup_size),
        .lookup_is_store(lookup_is_store),
        .lookup_data(lookup_data),
        .hit(hit),
        .line_block(line_block),
        .load_data(load_data),
        .fill(fill_bus.array_side)
    );

    mshr u_mshr (
        .clock(clock),
        .reset(reset),
        .req_valid(req_valid),
        .req_is_store(req_is_store),
        .req_addr(req_addr),
        .req_size(req_size),
        .req_data(req_data),
        .hit(hit),
        .line_block(line_block),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data(mem2proc_data),
        .mem2proc_data_tag(mem2proc_data_tag),
        .stall(stall),
        .load_valid(load_valid),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .proc2mem_data(proc2mem_data),
        .fill(fill_bus.mshr_side)
    );

endmodule

`default_nettype wire

/* logic/mshr.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr import dcache_pkg::*; (
    input  wire                 clock,
    input  wire                 reset,

    input  wire                 req_valid,
    input  wire                 req_is_store,
    input  wire  [ADDR_W-1:0]   req_addr,
    input  wire  mem_size_e     req_size,
    input  wire  [DATA_W-1:0]   req_data,

    input  wire                 hit,
    input  wire  [BLOCK_W-1:0]  line_block,

    input  wire  [TAG_W-1:0]    mem2proc_transaction_tag,
    input  wire  [BLOCK_W-1:0]  mem2proc_data,
    input  wire  [TAG_W-1:0]    mem2proc_data_tag,

    output logic                stall,
    output logic                load_valid,
    output mem_command_e        proc2mem_command,
    output logic [ADDR_W-1:0]   proc2mem_addr,
    output logic [BLOCK_W-1:0]  proc2mem_data,

    cache_fill_if.mshr_side     fill
);

    mshr_entry_t entry;
    mshr_entry_t entry_next;

    logic               busy;
    logic               accepted;
    logic [BLOCK_W-1:0] req_data_ext;

    assign busy         = (entry.state != IDLE);
    assign stall        = busy;
    assign accepted     = (mem2proc_transaction_tag != '0);
    assign req_data_ext = BLOCK_W'(req_data);

    // The array sees the entry while a miss or a retry is in flight
    assign fill.fill_addr  = entry.addr;
    assign fill.fill_block = mem2proc_data;
    assign fill.store_addr = busy ? entry.addr : req_addr;
    assign fill.store_size = busy ? entry.size : req_size;
    assign fill.store_data = busy ? entry.data : req_data_ext;

    always_comb begin
        entry_next       = entry;
        proc2mem_command = MEM_NONE;
        proc2mem_addr    = {entry.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        proc2mem_data    = '0;
        load_valid       = 1'b0;
        fill.fill_valid  = 1'b0;
        fill.store_valid = 1'b0;

        case (entry.state)
            IDLE: begin
                if (req_valid) begin
                    entry_next.addr     = req_addr;
                    entry_next.data     = req_data_ext;
                    entry_next.size     = req_size;
                    entry_next.is_store = req_is_store;
                    proc2mem_addr = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                    if (!hit) begin
                        proc2mem_command   = MEM_LOAD;
                        entry_next.mem_tag = mem2proc_transaction_tag;
                        entry_next.state   = accepted ? WAIT_DATA : WAIT_ACCEPT;
                    end else if (req_is_store) begin
                        fill.store_valid = 1'b1;
                        proc2mem_command = MEM_STORE;
                        proc2mem_data    = line_block;
                        if (!accepted) begin
                            entry_next.state = STORE_RETRY;
                        end
                    end else begin
                        load_valid = 1'b1;          // Load hit, zero cycles
                    end
                end
            end

            WAIT_ACCEPT: begin
                proc2mem_command   = MEM_LOAD;
                entry_next.mem_tag = mem2proc_transaction_tag;
                if (accepted) begin
                    entry_next.state = WAIT_DATA;
                end
            end

            WAIT_DATA: begin
                if (mem2proc_data_tag == entry.mem_tag) begin
                    fill.fill_valid  = 1'b1;
                    entry_next.state = IDLE;
                    if (entry.is_store) begin
                        fill.store_valid = 1'b1;
                        proc2mem_command = MEM_STORE;
                        proc2mem_data    = merge_store(mem2proc_data,
                            entry.addr[OFFSET_W-1:0], entry.size, entry.data);
                        if (!accepted) begin
                            entry_next.state = STORE_RETRY;
                        end
                    end else begin
                        load_valid = 1'b1;
                    end
                end
            end

            STORE_RETRY: begin
                proc2mem_command = MEM_STORE;
                proc2mem_data    = line_block;      // Line already holds the merged store
                if (accepted) begin
                    entry_next.state = IDLE;
                end
            end

            default: entry_next.state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry <= '0;
        end else begin
            entry <= entry_next;
        end
    end

endmodule

`default_nettype wire

/* src.f */
logic/dcache_pkg.sv
logic/cache_fill_if.sv
logic/dcache_array.sv
logic/mshr.sv
logic/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv
